//--- pwrPkg.sv
// Two switchable domains with fixed sequence timing
// State encodings are fixed at 4 bits and must match the testbench model order
package pwrPkg;

  // --------------------------------------------------
  // Domain and timing constants
  // --------------------------------------------------

  // Number of switchable power domains
  localparam int unsigned numDomains = 2;

  // Cycles spent in pwrOn2 before the restore pulse
  localparam int unsigned settleCycles = 28;
  localparam int unsigned settleCntWidth = 5;

  // --------------------------------------------------
  // Register map
  // --------------------------------------------------

  localparam int unsigned regAddrWidth = 2;
  localparam int unsigned regDataWidth = 32;

  localparam logic [regAddrWidth-1:0] addrReq = 2'd0;
  localparam logic [regAddrWidth-1:0] addrStatus = 2'd1;

  // --------------------------------------------------
  // Shutdown and restore states
  // --------------------------------------------------

  // Order matters, the testbench model mirrors it
  typedef enum logic [3:0] {
    stInit,
    stClkOff,
    stWait1,
    stIsolate,
    stSaveEdge,
    stPrePwrOff,
    stPwrOff,
    stPwrOn1,
    stPwrOn2,
    stRestoreEdge,
    stWait2,
    stDeIsolate,
    stClkOn,
    stWait3,
    stRstClr
  } pwrState_e;

endpackage

//--- pwrCtrlSm.sv
// One domain's shutoff sequencer, outputs are levels only for external cells
// Request is sampled only in init and pwrOff states
`timescale 1ns/1ps

module pwrCtrlSm (
  input  logic pclk4,
  input  logic nprst4,
  input  logic l1Req,
  output logic setStatus,
  output logic clrStatus,
  output logic rstnNonSrpgModule,
  output logic gateClk,
  output logic isolate,
  output logic saveEdge,
  output logic restoreEdge,
  output logic pwr1On,
  output logic pwr2On
);

  import pwrPkg::*;

  pwrState_e currentState;
  pwrState_e nextState;

  // Internal reset request for non-retention flops
  logic rstnNonSrpg;

  // Settling counter, only runs in pwrOn2
  logic [settleCntWidth-1:0] settleCnt;

  // --------------------------------------------------
  // Next state logic
  // --------------------------------------------------

  always_comb
  begin
    case (currentState)
      // Wait for a low-power request
      stInit:
      begin
        if (l1Req)
          nextState = stClkOff;
        else
          nextState = stInit;
      end
      // Clock gate then one cycle for it to settle
      stClkOff:
        nextState = stWait1;
      stWait1:
        nextState = stIsolate;
      stIsolate:
        nextState = stSaveEdge;
      // Retention save pulse
      stSaveEdge:
        nextState = stPrePwrOff;
      stPrePwrOff:
        nextState = stPwrOff;
      // Stay off until the request is cleared
      stPwrOff:
      begin
        if (!l1Req)
          nextState = stPwrOn1;
        else
          nextState = stPwrOff;
      end
      // Two-stage power-on
      stPwrOn1:
        nextState = stPwrOn2;
      stPwrOn2:
      begin
        if (settleCnt == settleCntWidth'(settleCycles))
          nextState = stRestoreEdge;
        else
          nextState = stPwrOn2;
      end
      stRestoreEdge:
        nextState = stWait2;
      stWait2:
        nextState = stDeIsolate;
      stDeIsolate:
        nextState = stClkOn;
      // Clock back on, wait one cycle before releasing reset
      stClkOn:
        nextState = stWait3;
      stWait3:
        nextState = stRstClr;
      stRstClr:
        nextState = stInit;
      default:
        nextState = stInit;
    endcase
  end

  always_ff @(posedge pclk4 or negedge nprst4)
  begin
    if (!nprst4)
      currentState <= stInit;
    else
      currentState <= nextState;
  end

  // --------------------------------------------------
  // Settling counter
  // --------------------------------------------------

  // Loads 1 on entry to pwrOn2 since it is zero elsewhere
  always_ff @(posedge pclk4 or negedge nprst4)
  begin
    if (!nprst4)
      settleCnt <= '0;
    else if (nextState == stPwrOn2)
      settleCnt <= settleCnt + 1'b1;
    else
      settleCnt <= '0;
  end

  // --------------------------------------------------
  // Registered controls, decoded from next state
  // --------------------------------------------------

  // Clock gated from clkOff up to deIsolate
  always_ff @(posedge pclk4 or negedge nprst4)
  begin
    if (!nprst4)
      gateClk <= 1'b0;
    else
      gateClk <= !(nextState inside {stInit, stClkOn, stWait3, stRstClr});
  end

  // Isolation held from isolate through wait2
  always_ff @(posedge pclk4 or negedge nprst4)
  begin
    if (!nprst4)
      isolate <= 1'b0;
    else
      isolate <= nextState inside {stIsolate, stSaveEdge, stPrePwrOff, stPwrOff,
                                   stPwrOn1, stPwrOn2, stRestoreEdge, stWait2};
  end

  // Single-cycle save pulse
  always_ff @(posedge pclk4 or negedge nprst4)
  begin
    if (!nprst4)
      saveEdge <= 1'b0;
    else
      saveEdge <= (nextState == stSaveEdge);
  end

  // Single-cycle restore pulse after settling
  always_ff @(posedge pclk4 or negedge nprst4)
  begin
    if (!nprst4)
      restoreEdge <= 1'b0;
    else
      restoreEdge <= (nextState == stRestoreEdge);
  end

  // First power switch returns in pwrOn1
  always_ff @(posedge pclk4 or negedge nprst4)
  begin
    if (!nprst4)
      pwr1On <= 1'b1;
    else
      pwr1On <= (nextState != stPwrOff);
  end

  // Second switch lags the first by one cycle
  always_ff @(posedge pclk4 or negedge nprst4)
  begin
    if (!nprst4)
      pwr2On <= 1'b1;
    else
      pwr2On <= !(nextState inside {stPwrOff, stPwrOn1});
  end

  // Reset released only in the run states and rstClr
  always_ff @(posedge pclk4 or negedge nprst4)
  begin
    if (!nprst4)
      rstnNonSrpg <= 1'b0;
    else
      rstnNonSrpg <= nextState inside {stInit, stClkOff, stWait1, stIsolate,
                                       stSaveEdge, stPrePwrOff, stRstClr};
  end

  // --------------------------------------------------
  // Combinational outputs
  // --------------------------------------------------

  // Held in reset at chip reset and while the domain is down
  assign rstnNonSrpgModule = rstnNonSrpg & nprst4;

  // Status strobes come from different states, never together
  assign setStatus = (nextState == stClkOff);
  assign clrStatus = (currentState == stRstClr);

endmodule

//--- pwrCtrlRegs.sv
// Request and status registers, every access completes in one cycle
// Status register is read only, writes to it are dropped
`timescale 1ns/1ps

module pwrCtrlRegs (
  input  logic                              pclk4,
  input  logic                              nprst4,
  input  logic                              regWrEn,
  input  logic [pwrPkg::regAddrWidth-1:0]   regAddr,
  input  logic [pwrPkg::regDataWidth-1:0]   regWrData,
  input  logic [pwrPkg::numDomains-1:0]     setStatus,
  input  logic [pwrPkg::numDomains-1:0]     clrStatus,
  output logic [pwrPkg::regDataWidth-1:0]   regRdData,
  output logic [pwrPkg::numDomains-1:0]     reqBits
);

  import pwrPkg::*;

  // Sticky shutoff status, one bit per domain
  logic [numDomains-1:0] statusBits;

  // --------------------------------------------------
  // Request register
  // --------------------------------------------------

  // Only the low bits of the write data are kept
  always_ff @(posedge pclk4 or negedge nprst4)
  begin
    if (!nprst4)
      reqBits <= '0;
    else if (regWrEn && (regAddr == addrReq))
      reqBits <= regWrData[numDomains-1:0];
  end

  // --------------------------------------------------
  // Status register
  // --------------------------------------------------

  // Set when shutdown starts, cleared in rstClr
  always_ff @(posedge pclk4 or negedge nprst4)
  begin
    if (!nprst4)
    begin
      statusBits <= '0;
    end
    else
    begin
      for (int d = 0; d < numDomains; d++)
      begin
        if (setStatus[d])
          statusBits[d] <= 1'b1;
        else if (clrStatus[d])
          statusBits[d] <= 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // Read mux
  // --------------------------------------------------

  // Unused addresses read zero
  always_comb
  begin
    regRdData = '0;
    case (regAddr)
      addrReq:
        regRdData[numDomains-1:0] = reqBits;
      addrStatus:
        regRdData[numDomains-1:0] = statusBits;
      default:
        regRdData = '0;
    endcase
  end

endmodule

//--- pwrCtrl.sv
// Power shutoff controller top, adds no latency over the blocks below
// One sequencer per domain, all sharing pclk4 and nprst4
`timescale 1ns/1ps

module pwrCtrl (
  input  logic                              pclk4,
  input  logic                              nprst4,
  input  logic                              regWrEn,
  input  logic [pwrPkg::regAddrWidth-1:0]   regAddr,
  input  logic [pwrPkg::regDataWidth-1:0]   regWrData,
  output logic [pwrPkg::regDataWidth-1:0]   regRdData,
  output logic [pwrPkg::numDomains-1:0]     gateClk,
  output logic [pwrPkg::numDomains-1:0]     isolate,
  output logic [pwrPkg::numDomains-1:0]     saveEdge,
  output logic [pwrPkg::numDomains-1:0]     restoreEdge,
  output logic [pwrPkg::numDomains-1:0]     pwr1On,
  output logic [pwrPkg::numDomains-1:0]     pwr2On,
  output logic [pwrPkg::numDomains-1:0]     rstnNonSrpgModule
);

  import pwrPkg::*;

  // Per-domain links between registers and sequencers
  logic [numDomains-1:0] reqBits;
  logic [numDomains-1:0] setStatus;
  logic [numDomains-1:0] clrStatus;

  // --------------------------------------------------
  // Register block
  // --------------------------------------------------

  pwrCtrlRegs i_regs (
    .pclk4     (pclk4),
    .nprst4    (nprst4),
    .regWrEn   (regWrEn),
    .regAddr   (regAddr),
    .regWrData (regWrData),
    .setStatus (setStatus),
    .clrStatus (clrStatus),
    .regRdData (regRdData),
    .reqBits   (reqBits)
  );

  // --------------------------------------------------
  // Domain sequencers
  // --------------------------------------------------

  // Request bit d drives sequencer d
  for (genvar d = 0; d < numDomains; d++)
  begin : gDomain
    pwrCtrlSm i_sm (
      .pclk4             (pclk4),
      .nprst4            (nprst4),
      .l1Req             (reqBits[d]),
      .setStatus         (setStatus[d]),
      .clrStatus         (clrStatus[d]),
      .rstnNonSrpgModule (rstnNonSrpgModule[d]),
      .gateClk           (gateClk[d]),
      .isolate           (isolate[d]),
      .saveEdge          (saveEdge[d]),
      .restoreEdge       (restoreEdge[d]),
      .pwr1On            (pwr1On[d]),
      .pwr2On            (pwr2On[d])
    );
  end

endmodule

//--- tbPwrCtrl.sv
// Cycle model of both domains is compared with the DUT at every falling edge
// Stimulus comes from a fixed-seed LCG and the run is bounded by a watchdog
`timescale 1ns/1ps

module tbPwrCtrl;

  import pwrPkg::*;

  // Model state numbers in the same order as the shutdown/restore sequence
  localparam int sInit = 0;
  localparam int sClkOff = 1;
  localparam int sIsolate = 3;
  localparam int sSaveEdge = 4;
  localparam int sPrePwrOff = 5;
  localparam int sPwrOff = 6;
  localparam int sPwrOn1 = 7;
  localparam int sPwrOn2 = 8;
  localparam int sRestoreEdge = 9;
  localparam int sWait2 = 10;
  localparam int sDeIsolate = 11;
  localparam int sRstClr = 14;

  // Watchdog budget is sequences times (longest sequence plus max idle) times 2
  localparam int numSeqs = 32;
  localparam int watchdogCycles = numSeqs * (60 + 40) * 2;

  logic pclk4;
  logic nprst4;
  logic regWrEn;
  logic [regAddrWidth-1:0] regAddr;
  logic [regDataWidth-1:0] regWrData;
  logic [regDataWidth-1:0] regRdData;
  logic [numDomains-1:0] gateClk;
  logic [numDomains-1:0] isolate;
  logic [numDomains-1:0] saveEdge;
  logic [numDomains-1:0] restoreEdge;
  logic [numDomains-1:0] pwr1On;
  logic [numDomains-1:0] pwr2On;
  logic [numDomains-1:0] rstnNonSrpgModule;

  // Model of sequencers, request register and status register
  int mState [numDomains];
  int mCnt [numDomains];
  logic [numDomains-1:0] mRstn;
  logic [numDomains-1:0] mReq;
  logic [numDomains-1:0] mStatus;

  logic [31:0] lcgState;
  string curTest;
  int errCount;
  int testErrStart;
  int testsPassed;
  int testsFailed;

  pwrCtrl i_dut (
    .pclk4             (pclk4),
    .nprst4            (nprst4),
    .regWrEn           (regWrEn),
    .regAddr           (regAddr),
    .regWrData         (regWrData),
    .regRdData         (regRdData),
    .gateClk           (gateClk),
    .isolate           (isolate),
    .saveEdge          (saveEdge),
    .restoreEdge       (restoreEdge),
    .pwr1On            (pwr1On),
    .pwr2On            (pwr2On),
    .rstnNonSrpgModule (rstnNonSrpgModule)
  );

  initial
  begin
    pclk4 = 1'b0;
    forever
      #5 pclk4 = ~pclk4;
  end

  initial
  begin
    #(watchdogCycles * 10);
    $display("Watchdog expired after %0d cycles, the run did not finish", watchdogCycles);
    $display("TEST FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  task automatic checkVal(input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("Error %s %s: expected %h, actual %h", curTest, what, expected, actual);
      errCount++;
    end
  endtask

  // One rising edge of the model where a request write lands after the sequencers sample it
  task automatic modelEdge(input logic wrEn, input logic [regAddrWidth-1:0] addr,
                           input logic [regDataWidth-1:0] data);
    int nxt;
    for (int d = 0; d < numDomains; d++)
    begin
      case (mState[d])
        sInit:
          nxt = mReq[d] ? sClkOff : sInit;
        sPwrOff:
          nxt = mReq[d] ? sPwrOff : sPwrOn1;
        sPwrOn2:
          nxt = (mCnt[d] == settleCycles) ? sRestoreEdge : sPwrOn2;
        sRstClr:
          nxt = sInit;
        default:
          nxt = mState[d] + 1;
      endcase
      // Status set on leaving init, cleared on leaving rstClr
      if (nxt == sClkOff)
        mStatus[d] = 1'b1;
      else if (mState[d] == sRstClr)
        mStatus[d] = 1'b0;
      mCnt[d] = (nxt == sPwrOn2) ? mCnt[d] + 1 : 0;
      mRstn[d] = (nxt <= sPrePwrOff) || (nxt == sRstClr);
      mState[d] = nxt;
    end
    if (wrEn && (addr == addrReq))
      mReq = data[numDomains-1:0];
  endtask

  task automatic checkOutputs();
    logic [numDomains-1:0] eGate;
    logic [numDomains-1:0] eIso;
    logic [numDomains-1:0] eSave;
    logic [numDomains-1:0] eRest;
    logic [numDomains-1:0] eP1;
    logic [numDomains-1:0] eP2;
    logic [numDomains-1:0] eRstn;
    logic [regDataWidth-1:0] eRd;
    int s;
    for (int d = 0; d < numDomains; d++)
    begin
      s = mState[d];
      eGate[d] = (s >= sClkOff) && (s <= sDeIsolate);
      eIso[d] = (s >= sIsolate) && (s <= sWait2);
      eSave[d] = (s == sSaveEdge);
      eRest[d] = (s == sRestoreEdge);
      eP1[d] = (s != sPwrOff);
      eP2[d] = (s != sPwrOff) && (s != sPwrOn1);
      eRstn[d] = mRstn[d] & nprst4;
    end
    eRd = '0;
    if (regAddr == addrReq)
      eRd[numDomains-1:0] = mReq;
    else if (regAddr == addrStatus)
      eRd[numDomains-1:0] = mStatus;
    checkVal("gateClk", eGate, gateClk);
    checkVal("isolate", eIso, isolate);
    checkVal("saveEdge", eSave, saveEdge);
    checkVal("restoreEdge", eRest, restoreEdge);
    checkVal("pwr1On", eP1, pwr1On);
    checkVal("pwr2On", eP2, pwr2On);
    checkVal("rstnNonSrpgModule", eRstn, rstnNonSrpgModule);
    checkVal("regRdData", eRd, regRdData);
  endtask

  // Called at a falling edge and returns at the next one after checking
  task automatic stepCycle(input logic wrEn, input logic [regAddrWidth-1:0] addr,
                           input logic [regDataWidth-1:0] data);
    regWrEn = wrEn;
    regAddr = addr;
    regWrData = data;
    @(posedge pclk4);
    if (nprst4)
      modelEdge(wrEn, addr, data);
    @(negedge pclk4);
    checkOutputs();
  endtask

  // sel 0 is pwr2On, 1 is restoreEdge, else rstnNonSrpgModule
  function automatic logic probe(input int sel, input int d);
    case (sel)
      0: return pwr2On[d];
      1: return restoreEdge[d];
      default: return rstnNonSrpgModule[d];
    endcase
  endfunction

  task automatic stepUntil(input int sel, input int d, input logic level, input int limit,
                           output int cycles);
    string sigName;
    sigName = (sel == 0) ? "pwr2On" : ((sel == 1) ? "restoreEdge" : "rstnNonSrpgModule");
    cycles = 0;
    while ((probe(sel, d) !== level) && (cycles < limit))
    begin
      stepCycle(1'b0, addrStatus, '0);
      cycles++;
    end
    if (probe(sel, d) !== level)
    begin
      $display("%s: %s of domain %0d did not reach %b within %0d cycles",
               curTest, sigName, d, level, limit);
      errCount++;
    end
  endtask

  task automatic beginTest(input string name);
    curTest = name;
    testErrStart = errCount;
  endtask

  task automatic endTest();
    if (errCount == testErrStart)
    begin
      testsPassed++;
      $display("%s finished, no errors", curTest);
    end
    else
    begin
      testsFailed++;
      $display("%s finished, %0d errors", curTest, errCount - testErrStart);
    end
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial
  begin
    int n;
    int d;
    logic [numDomains-1:0] reqVal;
    nprst4 = 1'b0;
    regWrEn = 1'b0;
    regAddr = addrReq;
    regWrData = '0;
    for (int i = 0; i < numDomains; i++)
    begin
      mState[i] = sInit;
      mCnt[i] = 0;
    end
    mRstn = '0;
    mReq = '0;
    mStatus = '0;
    lcgState = 32'h6e3b2151;
    errCount = 0;
    testsPassed = 0;
    testsFailed = 0;
    @(negedge pclk4);

    beginTest("resetValues");
    for (int i = 0; i < 5; i++)
      stepCycle(1'b0, regAddrWidth'(i % 2), '0);
    nprst4 = 1'b1;
    repeat (3) stepCycle(1'b0, addrReq, '0);
    endTest();

    // One edge loads the request, six more reach pwrOff
    beginTest("shutdownSeq");
    stepCycle(1'b1, addrReq, 32'h1);
    stepUntil(0, 0, 1'b0, 10, n);
    checkVal("edges to power off", 32'd6, n);
    stepCycle(1'b0, addrStatus, '0);
    endTest();

    beginTest("restoreSeq");
    stepCycle(1'b1, addrReq, 32'h0);
    stepUntil(0, 0, 1'b1, 5, n);
    stepUntil(1, 0, 1'b1, settleCycles + 5, n);
    checkVal("settle cycles", settleCycles, n);
    stepUntil(2, 0, 1'b1, 10, n);
    repeat (2) stepCycle(1'b0, addrStatus, '0);
    endTest();

    // Flip during shutdown, then request again while settling
    beginTest("midSeqFlip");
    stepCycle(1'b1, addrReq, 32'h2);
    repeat (3) stepCycle(1'b0, addrReq, '0);
    stepCycle(1'b1, addrReq, 32'h0);
    stepUntil(0, 1, 1'b0, 10, n);
    stepUntil(0, 1, 1'b1, 10, n);
    repeat (5) stepCycle(1'b0, addrStatus, '0);
    stepCycle(1'b1, addrReq, 32'h2);
    stepUntil(2, 1, 1'b1, 50, n);
    stepUntil(0, 1, 1'b0, 20, n);
    stepCycle(1'b1, addrReq, 32'h0);
    stepUntil(2, 1, 1'b1, 60, n);
    endTest();

    beginTest("bothDomains");
    reqVal = '0;
    repeat (20)
    begin
      d = nextRand() >> 31;
      reqVal[d] = ~reqVal[d];
      stepCycle(1'b1, addrReq, reqVal);
      n = (nextRand() >> 16) % 41;
      repeat (n) stepCycle(1'b0, regAddrWidth'(nextRand() >> 30), '0);
    end
    stepCycle(1'b1, addrReq, 32'h0);
    repeat (90) stepCycle(1'b0, addrStatus, '0);
    endTest();

    beginTest("regAccess");
    stepCycle(1'b1, addrStatus, 32'h3);
    stepCycle(1'b0, 2'd2, '0);
    checkVal("unused address 2", 32'h0, regRdData);
    stepCycle(1'b0, 2'd3, '0);
    checkVal("unused address 3", 32'h0, regRdData);
    // Only the domain bits of the write data are kept
    stepCycle(1'b1, addrReq, 32'hffff_fffd);
    stepCycle(1'b0, addrReq, '0);
    checkVal("request readback", 32'h1, regRdData);
    stepCycle(1'b1, addrReq, 32'h0);
    repeat (60) stepCycle(1'b0, addrStatus, '0);
    endTest();

    $display("Tests passed %0d, failed %0d", testsPassed, testsFailed);
    if (testsFailed == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- project.f
pwrPkg.sv
pwrCtrlSm.sv
pwrCtrlRegs.sv
pwrCtrl.sv
tbPwrCtrl.sv

//--- Bender.yml
package:
  name: pwrctrl

sources:
  - pwrPkg.sv
  - pwrCtrlSm.sv
  - pwrCtrlRegs.sv
  - pwrCtrl.sv
  - target: test
    files:
      - tbPwrCtrl.sv
